/* include/tile_defs.svh */
//////////////////////////////////////////////////////////////////////
// widths, flit field ranges, message codes and home node of the tile
// included by the package and by the modules that build or read flits
//////////////////////////////////////////////////////////////////////
`ifndef TILE_DEFS_SVH
`define TILE_DEFS_SVH

// bus and network widths
`define TILE_FLIT_WIDTH   64
`define TILE_ADDR_WIDTH   40
`define TILE_DATA_WIDTH   64
`define TILE_SEL_WIDTH    8
`define TILE_MSG_WIDTH    8
`define TILE_CHIPID_WIDTH 14
`define TILE_COORD_WIDTH  8
`define TILE_FBITS_WIDTH  4

// wake-up counter, top bit sets after 32 cycles
// silicon builds want 16 here so the home SRAMs finish init
`define TILE_WAKE_BITS 6

// header field ranges, bits 5:0 stay zero
`define TILE_F_CHIPID 63:50
`define TILE_F_X      49:42
`define TILE_F_Y      41:34
`define TILE_F_FBITS  33:30
`define TILE_F_LEN    29:22
`define TILE_F_TYPE   21:14
`define TILE_F_MASK   13:6

// payload lengths of the two request kinds
`define TILE_LEN_LOAD  8'd2
`define TILE_LEN_STORE 8'd3

// message types
`define TILE_MSG_NC_LOAD_REQ  8'd14
`define TILE_MSG_NC_STORE_REQ 8'd15
`define TILE_MSG_LOAD_ACK     8'd24
`define TILE_MSG_STORE_ACK    8'd25

// home L2 node and route bits
`define TILE_HOME_CHIPID 14'd0
`define TILE_HOME_X      8'd0
`define TILE_HOME_Y      8'd0
`define TILE_FBITS_L2    4'd0
`define TILE_FBITS_TILE  4'b1010

`endif

/* source/tile_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared types of the tile network side
// ports name these by scope, module bodies import the whole package
//////////////////////////////////////////////////////////////////////
`include "tile_defs.svh"

package tile_pkg;

  ////////////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////////////

  // one network word
  typedef logic [`TILE_FLIT_WIDTH-1:0] flit_t;
  // physical address
  typedef logic [`TILE_ADDR_WIDTH-1:0] addr_t;
  // one data word
  typedef logic [`TILE_DATA_WIDTH-1:0] data_t;
  // byte enables
  typedef logic [`TILE_SEL_WIDTH-1:0] sel_t;
  typedef logic [`TILE_MSG_WIDTH-1:0] msg_type_t;
  // node identity
  typedef logic [`TILE_CHIPID_WIDTH-1:0] chipid_t;
  typedef logic [`TILE_COORD_WIDTH-1:0] coord_t;
  typedef logic [`TILE_FBITS_WIDTH-1:0] fbits_t;

  ////////////////////////////////////////////////////////////////////
  // state machines
  ////////////////////////////////////////////////////////////////////

  // request serialiser, one state per flit
  typedef enum logic [2:0] {
    ENC_IDLE,
    ENC_HEADER,
    ENC_ADDR,
    ENC_SRC,
    ENC_DATA
  } enc_state_e;

  // response collector
  typedef enum logic [1:0] {
    DEC_WAIT_HDR,
    DEC_WAIT_DATA,
    DEC_DONE
  } dec_state_e;

  // wishbone side
  typedef enum logic [1:0] {
    BR_IDLE,
    BR_SEND,
    BR_WAIT,
    BR_FINISH
  } bridge_state_e;

endpackage

/* source/reset_sequencer.sv */
//////////////////////////////////////////////////////////////////////
// holds the tile in reset until the home SRAMs are up, then syncs it
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "tile_defs.svh"

module reset_sequencer (
  input  logic clk_i,
  input  logic reset_l,
  output logic grst_l_o
);

  // wake-up counter, freezes once the top bit is set
  logic [`TILE_WAKE_BITS-1:0] wake_cnt_q;
  logic                       wake_done;
  // gated reset ahead of the synchroniser
  logic                       rst_gated;
  logic                       sync1_q;
  logic                       sync2_q;

  assign wake_done = wake_cnt_q[`TILE_WAKE_BITS-1];

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      wake_cnt_q <= '0;
    end else if (!wake_done) begin
      wake_cnt_q <= wake_cnt_q + 1'b1;
    end
  end

  // release only after wake-up, assert at once on reset_l
  assign rst_gated = wake_done & reset_l;

  // two flop synchroniser
  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      sync1_q <= 1'b0;
      sync2_q <= 1'b0;
    end else begin
      sync1_q <= rst_gated;
      sync2_q <= sync1_q;
    end
  end

  assign grst_l_o = sync2_q;

  // tile stays in reset until the wake-up bit is set
  a_grst_needs_wake: assert property (@(posedge clk_i)
    !wake_done |-> !grst_l_o)
    else $error("tile reset high with wake-up counter still running");

endmodule

/* source/noc_flit_encoder.sv */
//////////////////////////////////////////////////////////////////////
// turns one latched load or store into request flits for the home L2
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "tile_defs.svh"

module noc_flit_encoder (
  input  logic              clk_i,
  input  logic              reset_l,
  // request from the bridge
  input  logic              enc_start_i,
  input  logic              enc_we_i,
  input  tile_pkg::addr_t   enc_adr_i,
  input  tile_pkg::data_t   enc_dat_i,
  input  tile_pkg::sel_t    enc_sel_i,
  // source identity
  input  tile_pkg::chipid_t src_chipid_i,
  input  tile_pkg::coord_t  src_x_i,
  input  tile_pkg::coord_t  src_y_i,
  output logic              enc_done_o,
  // network output
  output logic              noc_valid_o,
  output tile_pkg::flit_t   noc_data_o,
  input  logic              noc_ready_i
);
  import tile_pkg::*;

  enc_state_e state_q;
  enc_state_e state_d;
  logic       done_q;
  logic       last_flit;
  // request payload, held for the whole packet
  logic       we_q;
  addr_t      adr_q;
  data_t      dat_q;
  sel_t       sel_q;
  flit_t      hdr_flit;
  flit_t      src_flit;

  //////////////////////////////////////////////////////////////////////
  // flit contents
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    hdr_flit = '0;
    hdr_flit[`TILE_F_CHIPID] = `TILE_HOME_CHIPID;
    hdr_flit[`TILE_F_X] = `TILE_HOME_X;
    hdr_flit[`TILE_F_Y] = `TILE_HOME_Y;
    hdr_flit[`TILE_F_FBITS] = `TILE_FBITS_L2;
    if (we_q) begin
      hdr_flit[`TILE_F_LEN] = `TILE_LEN_STORE;
      hdr_flit[`TILE_F_TYPE] = `TILE_MSG_NC_STORE_REQ;
      hdr_flit[`TILE_F_MASK] = sel_q;
    end else begin
      // loads fetch the full word
      hdr_flit[`TILE_F_LEN] = `TILE_LEN_LOAD;
      hdr_flit[`TILE_F_TYPE] = `TILE_MSG_NC_LOAD_REQ;
      hdr_flit[`TILE_F_MASK] = '1;
    end
  end

  // return address of this tile, header layout
  always_comb begin
    src_flit = '0;
    src_flit[`TILE_F_CHIPID] = src_chipid_i;
    src_flit[`TILE_F_X] = src_x_i;
    src_flit[`TILE_F_Y] = src_y_i;
    src_flit[`TILE_F_FBITS] = `TILE_FBITS_TILE;
  end

  always_comb begin
    case (state_q)
      ENC_HEADER: noc_data_o = hdr_flit;
      ENC_ADDR:   noc_data_o = flit_t'(adr_q);
      ENC_SRC:    noc_data_o = src_flit;
      ENC_DATA:   noc_data_o = flit_t'(dat_q);
      default:    noc_data_o = '0;
    endcase
  end

  assign noc_valid_o = (state_q != ENC_IDLE);

  //////////////////////////////////////////////////////////////////////
  // sequencing
  //////////////////////////////////////////////////////////////////////

  // one step per accepted flit
  always_comb begin
    state_d = state_q;
    case (state_q)
      ENC_IDLE: begin
        if (enc_start_i) begin
          state_d = ENC_HEADER;
        end
      end
      ENC_HEADER: begin
        if (noc_ready_i) begin
          state_d = ENC_ADDR;
        end
      end
      ENC_ADDR: begin
        if (noc_ready_i) begin
          state_d = ENC_SRC;
        end
      end
      ENC_SRC: begin
        if (noc_ready_i) begin
          state_d = we_q ? ENC_DATA : ENC_IDLE;
        end
      end
      default: begin
        if (noc_ready_i) begin
          state_d = ENC_IDLE;
        end
      end
    endcase
  end

  // packet ends when a valid flit goes back to idle
  assign last_flit = noc_valid_o && noc_ready_i && (state_d == ENC_IDLE);

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      state_q <= ENC_IDLE;
      done_q <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q <= last_flit;
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == ENC_IDLE) && enc_start_i) begin
      we_q <= enc_we_i;
      adr_q <= enc_adr_i;
      dat_q <= enc_dat_i;
      sel_q <= enc_sel_i;
    end
  end

  assign enc_done_o = done_q;

  // an offered flit stays put until the network takes it
  a_flit_hold: assert property (@(posedge clk_i) disable iff (!reset_l)
    noc_valid_o && !noc_ready_i |=> noc_valid_o && $stable(noc_data_o))
    else $error("request flit changed under back-pressure");

endmodule

/* source/noc_flit_decoder.sv */
//////////////////////////////////////////////////////////////////////
// collects one response packet and holds its type and data
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "tile_defs.svh"

module noc_flit_decoder (
  input  logic                clk_i,
  input  logic                reset_l,
  // network input
  input  logic                noc_valid_i,
  input  tile_pkg::flit_t     noc_data_i,
  output logic                noc_ready_o,
  // to and from the bridge
  input  logic                dec_clear_i,
  output logic                dec_done_o,
  output tile_pkg::msg_type_t dec_msg_type_o,
  output tile_pkg::data_t     dec_data_o
);
  import tile_pkg::*;

  dec_state_e state_q;
  dec_state_e state_d;
  // ready is a flop so it is low while held in reset
  logic       rdy_q;
  logic       take;
  msg_type_t  type_q;
  data_t      data_q;

  assign take = noc_valid_i && rdy_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      DEC_WAIT_HDR: begin
        if (take) begin
          // store acks carry no data flit
          if (noc_data_i[`TILE_F_LEN] == 8'd0) begin
            state_d = DEC_DONE;
          end else begin
            state_d = DEC_WAIT_DATA;
          end
        end
      end
      DEC_WAIT_DATA: begin
        if (take) begin
          state_d = DEC_DONE;
        end
      end
      default: begin
        if (dec_clear_i) begin
          state_d = DEC_WAIT_HDR;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      state_q <= DEC_WAIT_HDR;
      rdy_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // stop taking flits while a result waits
      rdy_q <= (state_d != DEC_DONE);
    end
  end

  // header type and load word
  always_ff @(posedge clk_i) begin
    if (take && (state_q == DEC_WAIT_HDR)) begin
      type_q <= noc_data_i[`TILE_F_TYPE];
    end
    if (take && (state_q == DEC_WAIT_DATA)) begin
      data_q <= noc_data_i;
    end
  end

  assign noc_ready_o = rdy_q;
  assign dec_done_o = (state_q == DEC_DONE);
  assign dec_msg_type_o = type_q;
  assign dec_data_o = data_q;

  // single-word accesses only
  a_resp_len: assert property (@(posedge clk_i) disable iff (!reset_l)
    take && (state_q == DEC_WAIT_HDR) |-> noc_data_i[`TILE_F_LEN] <= 8'd1)
    else $error("response header with payload length above one");

endmodule

/* source/wb_noc_bridge.sv */
//////////////////////////////////////////////////////////////////////
// wishbone classic slave, one network request per bus cycle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "tile_defs.svh"

module wb_noc_bridge (
  input  logic                clk_i,
  input  logic                reset_l,
  // wishbone slave
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  tile_pkg::addr_t     wb_adr_i,
  input  tile_pkg::data_t     wb_dat_i,
  input  tile_pkg::sel_t      wb_sel_i,
  output tile_pkg::data_t     wb_dat_o,
  output logic                wb_ack_o,
  output logic                wb_err_o,
  // to and from the encoder
  output logic                enc_start_o,
  output logic                enc_we_o,
  output tile_pkg::addr_t     enc_adr_o,
  output tile_pkg::data_t     enc_dat_o,
  output tile_pkg::sel_t      enc_sel_o,
  input  logic                enc_done_i,
  // to and from the decoder
  output logic                dec_clear_o,
  input  logic                dec_done_i,
  input  tile_pkg::msg_type_t dec_msg_type_i,
  input  tile_pkg::data_t     dec_data_i
);
  import tile_pkg::*;

  bridge_state_e state_q;
  bridge_state_e state_d;
  logic          ack_q;
  logic          err_q;
  data_t         dat_q;
  msg_type_t     exp_type;
  logic          resp_in;
  logic          type_ok;

  // master holds the request fields until the answer
  assign enc_start_o = (state_q == BR_IDLE) && wb_cyc_i && wb_stb_i;
  assign enc_we_o = wb_we_i;
  assign enc_adr_o = wb_adr_i;
  assign enc_dat_o = wb_dat_i;
  assign enc_sel_o = wb_sel_i;

  // response kind must match the access kind
  assign exp_type = wb_we_i ? `TILE_MSG_STORE_ACK : `TILE_MSG_LOAD_ACK;
  assign type_ok = (dec_msg_type_i == exp_type);
  assign resp_in = (state_q == BR_WAIT) && dec_done_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      BR_IDLE: begin
        if (enc_start_o) begin
          state_d = BR_SEND;
        end
      end
      BR_SEND: begin
        if (enc_done_i) begin
          state_d = BR_WAIT;
        end
      end
      // dec_done is a level, so an early response is not lost
      BR_WAIT: begin
        if (dec_done_i) begin
          state_d = BR_FINISH;
        end
      end
      default: begin
        state_d = BR_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      state_q <= BR_IDLE;
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // answer lands in FINISH for one cycle
      ack_q <= resp_in && type_ok;
      err_q <= resp_in && !type_ok;
    end
  end

  always_ff @(posedge clk_i) begin
    if (resp_in) begin
      dat_q <= dec_data_i;
    end
  end

  assign dec_clear_o = (state_q == BR_FINISH);
  assign wb_dat_o = dat_q;
  assign wb_ack_o = ack_q;
  assign wb_err_o = err_q;

  // one answer per bus cycle, never both kinds
  a_one_answer: assert property (@(posedge clk_i) disable iff (!reset_l)
    (wb_ack_o || wb_err_o) |-> !(wb_ack_o && wb_err_o) ##1 !(wb_ack_o || wb_err_o))
    else $error("bus answer not a single ack or err pulse");

endmodule

/* source/tile_noc_wrap.sv */
//////////////////////////////////////////////////////////////////////
// tile memory side top, wishbone in and request/response network out
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tile_noc_wrap (
  input  logic              clk_i,
  input  logic              reset_l,
  output logic              grst_l_o,
  // tile identity
  input  tile_pkg::chipid_t src_chipid_i,
  input  tile_pkg::coord_t  src_x_i,
  input  tile_pkg::coord_t  src_y_i,
  // wishbone slave
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  tile_pkg::addr_t   wb_adr_i,
  input  tile_pkg::data_t   wb_dat_i,
  input  tile_pkg::sel_t    wb_sel_i,
  output tile_pkg::data_t   wb_dat_o,
  output logic              wb_ack_o,
  output logic              wb_err_o,
  // request network
  output logic              noc_valid_o,
  output tile_pkg::flit_t   noc_data_o,
  input  logic              noc_ready_i,
  // response network
  input  logic              noc_valid_i,
  input  tile_pkg::flit_t   noc_data_i,
  output logic              noc_ready_o
);
  import tile_pkg::*;

  // bridge to encoder
  logic      enc_start;
  logic      enc_we;
  addr_t     enc_adr;
  data_t     enc_dat;
  sel_t      enc_sel;
  logic      enc_done;
  // bridge to decoder
  logic      dec_clear;
  logic      dec_done;
  msg_type_t dec_msg_type;
  data_t     dec_data;

  reset_sequencer u_reset_seq (
    .clk_i    (clk_i),
    .reset_l  (reset_l),
    .grst_l_o (grst_l_o)
  );

  // everything below runs on the sequenced reset
  wb_noc_bridge u_bridge (
    .clk_i          (clk_i),
    .reset_l        (grst_l_o),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_sel_i       (wb_sel_i),
    .wb_dat_o       (wb_dat_o),
    .wb_ack_o       (wb_ack_o),
    .wb_err_o       (wb_err_o),
    .enc_start_o    (enc_start),
    .enc_we_o       (enc_we),
    .enc_adr_o      (enc_adr),
    .enc_dat_o      (enc_dat),
    .enc_sel_o      (enc_sel),
    .enc_done_i     (enc_done),
    .dec_clear_o    (dec_clear),
    .dec_done_i     (dec_done),
    .dec_msg_type_i (dec_msg_type),
    .dec_data_i     (dec_data)
  );

  noc_flit_encoder u_encoder (
    .clk_i        (clk_i),
    .reset_l      (grst_l_o),
    .enc_start_i  (enc_start),
    .enc_we_i     (enc_we),
    .enc_adr_i    (enc_adr),
    .enc_dat_i    (enc_dat),
    .enc_sel_i    (enc_sel),
    .src_chipid_i (src_chipid_i),
    .src_x_i      (src_x_i),
    .src_y_i      (src_y_i),
    .enc_done_o   (enc_done),
    .noc_valid_o  (noc_valid_o),
    .noc_data_o   (noc_data_o),
    .noc_ready_i  (noc_ready_i)
  );

  noc_flit_decoder u_decoder (
    .clk_i          (clk_i),
    .reset_l        (grst_l_o),
    .noc_valid_i    (noc_valid_i),
    .noc_data_i     (noc_data_i),
    .noc_ready_o    (noc_ready_o),
    .dec_clear_i    (dec_clear),
    .dec_done_o     (dec_done),
    .dec_msg_type_o (dec_msg_type),
    .dec_data_o     (dec_data)
  );

endmodule

/* testbench/noc_home_model.sv */
//////////////////////////////////////////////////////////////////////
// behavioural home L2 node, stores words and answers single requests
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "tile_defs.svh"

module noc_home_model (
  input  logic            clk_i,
  input  logic            reset_l,
  input  logic            stall_i,
  input  logic            fault_i,
  // requests from the tile
  input  logic            req_valid_i,
  input  tile_pkg::flit_t req_data_i,
  output logic            req_ready_o,
  // responses to the tile
  output logic            rsp_valid_o,
  output tile_pkg::flit_t rsp_data_o,
  input  logic            rsp_ready_i
);
  import tile_pkg::*;

  data_t     mem [0:15];
  flit_t     pkt [0:3];
  flit_t     rsp_data_flit;
  // handshakes seen at the rising edge
  flit_t     req_flit = '0;
  logic      req_take = 1'b0;
  logic      rsp_take = 1'b0;
  int        cnt;
  int        rsp_left;
  logic [3:0] idx;
  logic      is_store;
  msg_type_t ack_type;

  // word memory, pattern tied to the word address
  initial begin
    for (int i = 0; i < 16; i++) begin
      mem[i] = {16{i[3:0]}} ^ 64'h0123_4567_89ab_cdef;
    end
    cnt = 0;
    rsp_left = 0;
    rsp_valid_o = 1'b0;
    rsp_data_o = '0;
  end

  // stalls only hold off request flits
  assign req_ready_o = !stall_i;

  always @(posedge clk_i) begin
    req_take <= req_valid_i && req_ready_o;
    req_flit <= req_data_i;
    rsp_take <= rsp_valid_o && rsp_ready_i;
  end

  always @(negedge clk_i) begin
    if (!reset_l) begin
      cnt = 0;
      rsp_left = 0;
      rsp_valid_o = 1'b0;
      rsp_data_o = '0;
    end else begin
      // step through the response packet
      if (rsp_take) begin
        rsp_left = rsp_left - 1;
        rsp_data_o = rsp_data_flit;
        rsp_valid_o = (rsp_left != 0);
      end
      if (req_take && cnt < 4) begin
        pkt[cnt] = req_flit;
        cnt = cnt + 1;
        // header length counts the flits after it
        if (cnt == int'(pkt[0][`TILE_F_LEN]) + 1) begin
          cnt = 0;
          idx = pkt[1][6:3];
          is_store = (pkt[0][`TILE_F_TYPE] == `TILE_MSG_NC_STORE_REQ);
          // faulted stores leave memory alone
          if (is_store && !fault_i) begin
            for (int b = 0; b < 8; b++) begin
              if (pkt[0][6+b]) begin
                mem[idx][8*b +: 8] = pkt[3][8*b +: 8];
              end
            end
          end
          ack_type = is_store ? `TILE_MSG_STORE_ACK : `TILE_MSG_LOAD_ACK;
          // fault mode swaps the two ack kinds
          if (fault_i) begin
            ack_type = is_store ? `TILE_MSG_LOAD_ACK : `TILE_MSG_STORE_ACK;
          end
          rsp_data_o = '0;
          rsp_data_o[63:30] = pkt[2][63:30];
          rsp_data_o[`TILE_F_LEN] = is_store ? 8'd0 : 8'd1;
          rsp_data_o[`TILE_F_TYPE] = ack_type;
          rsp_data_flit = mem[idx];
          rsp_left = is_store ? 1 : 2;
          rsp_valid_o = 1'b1;
        end
      end
    end
  end

endmodule

/* testbench/tb_tile_noc_wrap.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the tile network side, wishbone master plus home node
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "tile_defs.svh"

module tb_tile_noc_wrap;
  import tile_pkg::*;

  localparam int clk_period = 4;
  localparam int n_access = 49;
  localparam int wd_cycles = 16 + 34 + 60 * n_access;
  // per bus cycle answer limit
  localparam int access_limit = 200;
  localparam chipid_t src_chipid = 14'h2a5;
  localparam coord_t src_x = 8'h03;
  localparam coord_t src_y = 8'h07;

  logic    clk_i = 1'b0;
  logic    reset_l;
  logic    grst_l_o;
  chipid_t src_chipid_i;
  coord_t  src_x_i;
  coord_t  src_y_i;
  logic    wb_cyc_i;
  logic    wb_stb_i;
  logic    wb_we_i;
  addr_t   wb_adr_i;
  data_t   wb_dat_i;
  sel_t    wb_sel_i;
  data_t   wb_dat_o;
  logic    wb_ack_o;
  logic    wb_err_o;
  logic    noc_valid_o;
  flit_t   noc_data_o;
  logic    noc_ready_i;
  logic    noc_valid_i;
  flit_t   noc_data_i;
  logic    noc_ready_o;
  // home node controls
  logic    stall = 1'b0;
  logic    stall_en;
  logic    fault;
  logic [31:0] stall_rnd;
  integer  seed = 32'h09cdc773;
  int      checks = 0;
  int      errors = 0;
  int      checks_mark = 0;
  int      errors_mark = 0;
  data_t   shadow [0:15];
  flit_t   exp_flits [$];

  always #(clk_period / 2) clk_i = ~clk_i;

  tile_noc_wrap uut (.*);

  noc_home_model u_home (
    .clk_i       (clk_i),
    .reset_l     (reset_l),
    .stall_i     (stall),
    .fault_i     (fault),
    .req_valid_i (noc_valid_o),
    .req_data_i  (noc_data_o),
    .req_ready_o (noc_ready_i),
    .rsp_valid_o (noc_valid_i),
    .rsp_data_o  (noc_data_i),
    .rsp_ready_i (noc_ready_o)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic data_t fill_word(input logic [3:0] idx);
    return {16{idx}} ^ 64'h0123_4567_89ab_cdef;
  endfunction

  function automatic addr_t word_addr(input logic [3:0] idx);
    return {33'h0_0080_0000, idx, 3'b000};
  endfunction

  // home destination, loads always ask for every byte
  function automatic flit_t exp_header(input logic we, input sel_t sel);
    flit_t f;
    f = '0;
    f[`TILE_F_CHIPID] = `TILE_HOME_CHIPID;
    f[`TILE_F_X] = `TILE_HOME_X;
    f[`TILE_F_Y] = `TILE_HOME_Y;
    f[`TILE_F_FBITS] = `TILE_FBITS_L2;
    f[`TILE_F_LEN] = we ? 8'd3 : 8'd2;
    f[`TILE_F_TYPE] = we ? `TILE_MSG_NC_STORE_REQ : `TILE_MSG_NC_LOAD_REQ;
    f[`TILE_F_MASK] = we ? sel : 8'hff;
    return f;
  endfunction

  function automatic flit_t exp_src_flit();
    flit_t f;
    f = '0;
    f[`TILE_F_CHIPID] = src_chipid;
    f[`TILE_F_X] = src_x;
    f[`TILE_F_Y] = src_y;
    f[`TILE_F_FBITS] = `TILE_FBITS_TILE;
    return f;
  endfunction

  function automatic data_t merge_word(input data_t old, input data_t nw, input sel_t sel);
    data_t w;
    w = old;
    for (int b = 0; b < 8; b++) begin
      if (sel[b]) begin
        w[8*b +: 8] = nw[8*b +: 8];
      end
    end
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_flit(input flit_t got, input flit_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // every taken request flit against the expected packet, in order
  always @(posedge clk_i) begin
    if (noc_valid_o && noc_ready_i) begin
      if (exp_flits.size() == 0) begin
        errors++;
        $display("request flit %h sent with no bus cycle pending", noc_data_o);
      end else begin
        check_flit(noc_data_o, exp_flits.pop_front(), "request flit");
      end
    end
  end

  // random back-pressure on the request network
  always @(negedge clk_i) begin
    if (stall_en) begin
      stall_rnd = $random(seed);
      stall <= stall_rnd[0];
    end else begin
      stall <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bus cycles and test flow
  //////////////////////////////////////////////////////////////////////

  task automatic bus_access(input logic we, input logic [3:0] idx, input data_t dat,
                            input sel_t sel, input logic expect_err);
    addr_t adr;
    int    waited;
    adr = word_addr(idx);
    exp_flits.push_back(exp_header(we, sel));
    exp_flits.push_back(flit_t'(adr));
    exp_flits.push_back(exp_src_flit());
    if (we) begin
      exp_flits.push_back(flit_t'(dat));
    end
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    waited = 0;
    // answer is a one cycle pulse, seen at a falling edge
    do begin
      @(negedge clk_i);
      waited++;
    end while (!(wb_ack_o || wb_err_o) && waited < access_limit);
    if (!(wb_ack_o || wb_err_o)) begin
      errors++;
      $display("bus cycle to %h got neither ack nor err in %0d cycles", adr, access_limit);
    end else begin
      check_bit(wb_ack_o, !expect_err, "wb_ack_o");
      check_bit(wb_err_o, expect_err, "wb_err_o");
      if (!we && !expect_err) begin
        check_data(wb_dat_o, shadow[idx], "load data");
      end
      if (we && !expect_err) begin
        shadow[idx] = merge_word(shadow[idx], dat, sel);
      end
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    if (exp_flits.size() != 0) begin
      errors++;
      $display("request packet to %h ended %0d flits short", adr, exp_flits.size());
      exp_flits.delete();
    end
  endtask

  task automatic test_done(input string name);
    $display("test %s: %0d checks, %0d failed", name, checks - checks_mark,
             errors - errors_mark);
    checks_mark = checks;
    errors_mark = errors;
  endtask

  initial begin
    logic [31:0] rnd;
    int          cyc;
    reset_l = 1'b0;
    src_chipid_i = src_chipid;
    src_x_i = src_x;
    src_y_i = src_y;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    stall_en = 1'b0;
    fault = 1'b0;
    for (int i = 0; i < 16; i++) begin
      shadow[i] = fill_word(i[3:0]);
    end

    // reset release, 32 wake-up cycles plus two sync flops
    repeat (16) begin
      @(negedge clk_i);
      check_bit(grst_l_o, 1'b0, "grst_l_o under reset");
    end
    reset_l = 1'b1;
    cyc = 0;
    while (grst_l_o !== 1'b1 && cyc < 100) begin
      @(negedge clk_i);
      cyc++;
      check_bit(noc_valid_o, 1'b0, "noc_valid_o before release");
      check_bit(noc_ready_o, 1'b0, "noc_ready_o before release");
      check_bit(wb_ack_o, 1'b0, "wb_ack_o before release");
      check_bit(wb_err_o, 1'b0, "wb_err_o before release");
    end
    check_count(cyc, 34, "cycles to grst_l_o release");
    test_done("reset_release");

    bus_access(1'b1, 4'd1, 64'hdead_beef_cafe_f00d, 8'hff, 1'b0);
    test_done("store_encoding");

    bus_access(1'b1, 4'd2, 64'h1111_2222_3333_4444, 8'h0f, 1'b0);
    bus_access(1'b1, 4'd2, 64'haaaa_bbbb_cccc_dddd, 8'hc0, 1'b0);
    bus_access(1'b0, 4'd2, '0, 8'h00, 1'b0);
    test_done("load_byte_masks");

    stall_en = 1'b1;
    bus_access(1'b1, 4'd1, 64'h0f0e_0d0c_0b0a_0908, 8'h3c, 1'b0);
    bus_access(1'b0, 4'd1, '0, 8'h00, 1'b0);
    bus_access(1'b0, 4'd2, '0, 8'h00, 1'b0);
    test_done("back_pressure");

    // swapped ack type, then a clean load of the same word
    fault = 1'b1;
    bus_access(1'b1, 4'd3, 64'h5555_6666_7777_8888, 8'hff, 1'b1);
    fault = 1'b0;
    bus_access(1'b0, 4'd3, '0, 8'h00, 1'b0);
    test_done("wrong_response");

    for (int n = 0; n < 40; n++) begin
      rnd = $random(seed);
      bus_access(rnd[0], rnd[4:1], {$random(seed), $random(seed)}, rnd[12:5], 1'b0);
    end
    stall_en = 1'b0;
    test_done("random_mix");

    $display("checks run: %0d, failed: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // whole run limit
  initial begin
    #(wd_cycles * clk_period);
    $display("watchdog expired, run still going after %0d cycles", wd_cycles);
    $display("Errors found");
    $finish;
  end

endmodule

/* sim.f */
+incdir+include
source/tile_pkg.sv
source/reset_sequencer.sv
source/noc_flit_encoder.sv
source/noc_flit_decoder.sv
source/wb_noc_bridge.sv
source/tile_noc_wrap.sv
testbench/noc_home_model.sv
testbench/tb_tile_noc_wrap.sv

/* Makefile */
# Verilator build and run of the tile network side testbench

VERILATOR ?= verilator
TOP       := tb_tile_noc_wrap
FILELIST  := sim.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'No errors'

clean:
	rm -rf $(OBJDIR)
